/* Makefile */
# Verilator build and run of the blur testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module blur_tb -f src.f -Mdir obj_dir -o blur_sim
	-./obj_dir/blur_sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir sim.log

/* blur_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module blur_checker #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 6
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              in_wr_en,
    input  wire image_pkg::pixel_t in_din,
    input  wire logic              in_full,
    input  wire logic              out_rd_en,
    input  wire image_pkg::pixel_t out_dout,
    input  wire logic              out_empty,
    input  wire logic              end_of_test,
    output int                     checked_count,
    output int                     mismatch_count,
    output int                     other_count,
    output int                     pending
);

    localparam int FRAME_PIX = WIDTH * HEIGHT;

    // every pixel the input FIFO accepted since the last reset
    image_pkg::pixel_t in_pix [$];
    // outputs read since the last reset, raster order across frames
    int out_idx;
    // set by reset, cleared by the first new input pixel
    bit after_reset;
    // sticky, back-pressure reached the source
    bit full_seen;

    // weighted mean over the neighbours that lie inside the frame
    function automatic image_pkg::pixel_t expected_pixel(input int base, input int r, input int c);
        int sum;
        int wts;
        int rr;
        int cc;
        int q;
        sum = 0;
        wts = 0;
        for (int di = -2; di <= 2; di++) begin
            for (int dj = -2; dj <= 2; dj++) begin
                rr = r + di;
                cc = c + dj;
                if (rr >= 0 && rr < HEIGHT && cc >= 0 && cc < WIDTH) begin
                    sum = sum + int'(in_pix[base + rr * WIDTH + cc])
                              * int'(image_pkg::KERNEL[di + 2][dj + 2]);
                    wts = wts + int'(image_pkg::KERNEL[di + 2][dj + 2]);
                end
            end
        end
        // truncating division, capped to one byte
        q = sum / wts;
        if (q > 255) begin
            q = 255;
        end
        return image_pkg::pixel_t'(q);
    endfunction

    task automatic check_read();
        int base;
        int r;
        int c;
        int last;
        image_pkg::pixel_t exp;
        base = (out_idx / FRAME_PIX) * FRAME_PIX;
        r    = (out_idx % FRAME_PIX) / WIDTH;
        c    = out_idx % WIDTH;
        // furthest input the window of this pixel reaches
        last = base + ((r + 2 < HEIGHT) ? r + 2 : HEIGHT - 1) * WIDTH
                    + ((c + 2 < WIDTH) ? c + 2 : WIDTH - 1);
        if (last >= in_pix.size()) begin
            other_count++;
            $display("output pixel %0d was read before its input pixels were written", out_idx);
        end else begin
            exp = expected_pixel(base, r, c);
            checked_count++;
            if (out_dout !== exp) begin
                mismatch_count++;
                $display("[ERROR] out_dout frame %0d row %0d col %0d: expected %h actual %h",
                         out_idx / FRAME_PIX, r, c, exp, out_dout);
            end
        end
        out_idx++;
    endtask

    always @(posedge clock) begin
        if (reset) begin
            // partial frame is gone with the DUT state
            in_pix.delete();
            out_idx     = 0;
            after_reset = 1'b1;
        end else begin
            if (in_full) begin
                full_seen = 1'b1;
            end
            if (after_reset && !out_empty) begin
                other_count++;
                after_reset = 1'b0;
                $display("output FIFO holds data after reset although no new input arrived");
            end
            if (in_wr_en && !in_full) begin
                in_pix.push_back(in_din);
                after_reset = 1'b0;
            end
            if (out_rd_en && !out_empty) begin
                check_read();
            end
            if (end_of_test) begin
                if (in_pix.size() != out_idx) begin
                    other_count++;
                    $display("%0d pixels written but %0d outputs read at the end of the run",
                             in_pix.size(), out_idx);
                end
                if (!out_empty) begin
                    other_count++;
                    $display("output FIFO still holds unread pixels at the end of the run");
                end
                if (!full_seen) begin
                    other_count++;
                    $display("input FIFO never reported full during the run");
                end
            end
            pending = in_pix.size() - out_idx;
        end
    end

endmodule

`default_nettype wire

/* blur_divider.sv */
`timescale 1ns/1ns
`default_nettype none

module blur_divider (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              start,
    input  wire image_pkg::wsum_t  dividend,
    input  wire image_pkg::wtot_t  divisor,
    output logic                   done,
    output image_pkg::pixel_t      quotient
);

    // one quotient bit per cycle
    localparam int STEPS  = $bits(image_pkg::wsum_t);
    localparam int STEP_W = $clog2(STEPS);
    localparam int REM_W  = $bits(image_pkg::wtot_t);

    logic              busy;
    logic [STEP_W-1:0] step_cnt;
    logic              last_step;

    // shifting dividend, quotient bits enter at the bottom
    image_pkg::wsum_t quo;
    image_pkg::wsum_t src_quo;
    image_pkg::wsum_t quo_next;
    // partial remainder, always below the divisor
    image_pkg::wtot_t rem;
    image_pkg::wtot_t src_rem;
    image_pkg::wtot_t rem_next;
    image_pkg::wtot_t dsr;
    image_pkg::wtot_t src_dsr;
    logic [REM_W:0]   partial;

    // sixteenth step, the one that lands on step_cnt 15
    assign last_step = busy && (step_cnt == STEP_W'(STEPS - 1));

    // first step runs straight from the inputs on the start cycle
    always_comb begin
        src_quo = start ? dividend : quo;
        src_rem = start ? '0 : rem;
        src_dsr = start ? divisor : dsr;
        partial = {src_rem, src_quo[STEPS-1]};
        // restoring step: subtract only when it fits
        if (partial >= {1'b0, src_dsr}) begin
            rem_next = REM_W'(partial - {1'b0, src_dsr});
            quo_next = {src_quo[STEPS-2:0], 1'b1};
        end else begin
            rem_next = partial[REM_W-1:0];
            quo_next = {src_quo[STEPS-2:0], 1'b0};
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= last_step;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= STEP_W'(1);
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start || busy) begin
            quo <= quo_next;
            rem <= rem_next;
        end
        if (start) begin
            dsr <= divisor;
        end
        // saturate anything above one byte
        if (last_step) begin
            quotient <= (quo_next[STEPS-1:8] != '0) ? 8'hff : quo_next[7:0];
        end
    end

    // a zero weight total would mean no tap was in frame
    a_divisor_nonzero: assert property (
        @(posedge clock) disable iff (reset)
        start |-> (divisor != '0)
    );

    // result lands exactly 16 cycles after the request
    a_fixed_latency: assert property (
        @(posedge clock) disable iff (reset)
        start |-> ##16 done
    );

    // requester waits for done before the next start
    a_no_overlap: assert property (
        @(posedge clock) disable iff (reset)
        start |-> !busy
    );

endmodule

`default_nettype wire

/* blur_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module blur_tb;

    localparam int WIDTH      = 8;
    localparam int HEIGHT     = 6;
    localparam int FIFO_DEPTH = 16;
    localparam int FRAME_PIX  = WIDTH * HEIGHT;
    localparam int NUM_FRAMES = 10;

    // pattern kinds
    localparam int KIND_CONST = 0;
    localparam int KIND_RAMP  = 1;
    localparam int KIND_RAND  = 2;

    // 40 cycles per pixel at 20 ns, times 4, plus room for drains and resets
    localparam int TIMEOUT_NS = NUM_FRAMES * FRAME_PIX * 40 * 20 * 4 + 50000;

    typedef struct {
        int                kind;
        image_pkg::pixel_t fill;
        bit                gaps;
        bit                stalls;
        bit                cut;
    } frame_row_t;

    frame_row_t frame_table [NUM_FRAMES];

    logic              clock;
    logic              reset;
    logic              in_wr_en;
    image_pkg::pixel_t in_din;
    logic              in_full;
    logic              out_rd_en;
    image_pkg::pixel_t out_dout;
    logic              out_empty;
    logic              end_of_test;
    bit                stall_mode;

    int checked_count;
    int mismatch_count;
    int other_count;
    int pending;

    int seed      = 32'hb92a;
    int read_seed = 32'hb92a;

    blur_top #(
        .WIDTH      (WIDTH),
        .HEIGHT     (HEIGHT),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_blur_top (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    blur_checker #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) u_checker (
        .clock          (clock),
        .reset          (reset),
        .in_wr_en       (in_wr_en),
        .in_din         (in_din),
        .in_full        (in_full),
        .out_rd_en      (out_rd_en),
        .out_dout       (out_dout),
        .out_empty      (out_empty),
        .end_of_test    (end_of_test),
        .checked_count  (checked_count),
        .mismatch_count (mismatch_count),
        .other_count    (other_count),
        .pending        (pending)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic idle_cycles(input int n);
        in_wr_en = 1'b0;
        repeat (n) @(negedge clock);
    endtask

    // called on a falling edge, holds off while the input FIFO is full
    task automatic write_pixel(input image_pkg::pixel_t pix);
        while (in_full) begin
            in_wr_en = 1'b0;
            @(negedge clock);
        end
        in_wr_en = 1'b1;
        in_din   = pix;
        @(negedge clock);
        in_wr_en = 1'b0;
    endtask

    task automatic send_frame(input frame_row_t row, input int count);
        image_pkg::pixel_t pix;
        for (int i = 0; i < count; i++) begin
            if (row.gaps && ($unsigned($random(seed)) % 2 == 0)) begin
                idle_cycles(int'($unsigned($random(seed)) % 8));
            end
            case (row.kind)
                KIND_CONST: pix = row.fill;
                KIND_RAMP:  pix = image_pkg::pixel_t'(int'(row.fill) + i * 5);
                default:    pix = image_pkg::pixel_t'($random(seed));
            endcase
            write_pixel(pix);
        end
    endtask

    task automatic apply_reset();
        in_wr_en = 1'b0;
        reset    = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b0;
    endtask

    // every written pixel has been read back
    task automatic wait_drained();
        in_wr_en = 1'b0;
        while (pending != 0) begin
            @(negedge clock);
        end
    endtask

    // sink, with bursts of idle cycles in stall mode
    initial begin
        int hold;
        hold      = 0;
        out_rd_en = 1'b0;
        forever begin
            @(negedge clock);
            if (hold > 0) begin
                out_rd_en = 1'b0;
                hold--;
            end else if (!out_empty) begin
                out_rd_en = 1'b1;
                if (stall_mode) begin
                    hold = int'($unsigned($random(read_seed)) % 64);
                end
            end else begin
                out_rd_en = 1'b0;
            end
        end
    end

    initial begin
        // kind, fill, input gaps, output stalls, reset in mid-frame
        frame_table = '{
            '{KIND_CONST, 8'h80, 1'b0, 1'b0, 1'b0},
            '{KIND_CONST, 8'hff, 1'b0, 1'b0, 1'b0},
            '{KIND_RAMP,  8'h00, 1'b0, 1'b0, 1'b0},
            '{KIND_RAND,  8'h00, 1'b0, 1'b0, 1'b0},
            '{KIND_RAND,  8'h00, 1'b0, 1'b1, 1'b0},
            '{KIND_RAMP,  8'h37, 1'b1, 1'b0, 1'b0},
            '{KIND_RAND,  8'h00, 1'b1, 1'b1, 1'b0},
            '{KIND_CONST, 8'h10, 1'b0, 1'b0, 1'b1},
            '{KIND_RAND,  8'h00, 1'b0, 1'b0, 1'b0},
            '{KIND_CONST, 8'h01, 1'b0, 1'b1, 1'b0}
        };
        reset       = 1'b1;
        in_wr_en    = 1'b0;
        in_din      = '0;
        end_of_test = 1'b0;
        stall_mode  = 1'b0;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        // frames go back to back unless a reset is due
        for (int f = 0; f < NUM_FRAMES; f++) begin
            stall_mode = frame_table[f].stalls;
            if (frame_table[f].cut) begin
                wait_drained();
                send_frame(frame_table[f], FRAME_PIX / 2);
                idle_cycles(10);
                apply_reset();
                // quiet period, checker watches out_empty
                idle_cycles(40);
            end else begin
                send_frame(frame_table[f], FRAME_PIX);
            end
        end

        wait_drained();
        idle_cycles(20);
        end_of_test = 1'b1;
        @(negedge clock);
        end_of_test = 1'b0;

        $display("closing report: %0d pixels checked, %0d mismatches, %0d other errors",
                 checked_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run timed out after %0d ns with %0d pixels pending",
                 TIMEOUT_NS, pending);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* blur_top.sv */
`timescale 1ns/1ns
`default_nettype none

module blur_top #(
    parameter int WIDTH      = 8,
    parameter int HEIGHT     = 6,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              in_wr_en,
    input  wire image_pkg::pixel_t in_din,
    output logic                   in_full,
    input  wire logic              out_rd_en,
    output image_pkg::pixel_t      out_dout,
    output logic                   out_empty
);

    // input FIFO to engine
    logic              in_fifo_rd_en;
    image_pkg::pixel_t in_fifo_dout;
    logic              in_fifo_empty;

    // engine to output FIFO
    logic              out_fifo_wr_en;
    image_pkg::pixel_t out_fifo_din;
    logic              out_fifo_full;

    // raster pixels from the source
    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (in_fifo_rd_en),
        .dout  (in_fifo_dout),
        .empty (in_fifo_empty)
    );

    gaussian_blur #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) u_blur (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (in_fifo_rd_en),
        .in_empty  (in_fifo_empty),
        .in_dout   (in_fifo_dout),
        .out_wr_en (out_fifo_wr_en),
        .out_full  (out_fifo_full),
        .out_din   (out_fifo_din)
    );

    // blurred pixels towards the sink
    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_fifo_wr_en),
        .din   (out_fifo_din),
        .full  (out_fifo_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

`default_nettype wire

/* gaussian_blur.sv */
`timescale 1ns/1ns
`default_nettype none

module gaussian_blur #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 6
) (
    input  wire logic              clock,
    input  wire logic              reset,
    output logic                   in_rd_en,
    input  wire logic              in_empty,
    input  wire image_pkg::pixel_t in_dout,
    output logic                   out_wr_en,
    input  wire logic              out_full,
    output image_pkg::pixel_t      out_din
);

    localparam int KSIZE        = image_pkg::KSIZE;
    // four full lines plus one window row
    localparam int SHIFT_LEN    = 4 * WIDTH + 5;
    // pixels needed before (0,0) sits in the window centre
    localparam int PROLOGUE_LEN = 2 * WIDTH + 3;
    localparam int PIXEL_COUNT  = WIDTH * HEIGHT;
    localparam int CNT_W        = $clog2(PROLOGUE_LEN + 1);
    localparam int COL_W        = (WIDTH > 1) ? $clog2(WIDTH) : 1;
    localparam int ROW_W        = (HEIGHT > 1) ? $clog2(HEIGHT) : 1;

    image_pkg::blur_state_t state;
    image_pkg::blur_state_t next_state;

    // line buffer with the oldest pixel at index 0
    image_pkg::pixel_t [0:SHIFT_LEN-1] line_buf;
    logic              shift_en;
    image_pkg::pixel_t shift_pix;

    logic [CNT_W-1:0] prologue_cnt;
    // coordinates of the window centre
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;

    // frame pixels all read so zeros get padded in
    logic feed_done;
    logic last_pix;
    logic frame_end;

    // per column partial sums of the window
    image_pkg::wsum_t col_sum [KSIZE];
    image_pkg::wtot_t col_wt  [KSIZE];
    image_pkg::wsum_t win_sum;
    image_pkg::wtot_t win_wt;

    logic              div_start;
    logic              div_done;
    image_pkg::pixel_t div_quotient;

    // pixel shifted in during FILTER is centre index plus prologue length
    assign feed_done = (int'(row) * WIDTH + int'(col) + PROLOGUE_LEN) >= PIXEL_COUNT;
    assign last_pix  = (row == ROW_W'(HEIGHT - 1)) && (col == COL_W'(WIDTH - 1));

    // divider holds its result until the next done
    assign out_din = div_quotient;

    // window MAC with border masking
    always_comb begin
        int tap_row;
        int tap_col;
        win_sum = '0;
        win_wt  = '0;
        for (int j = 0; j < KSIZE; j++) begin
            col_sum[j] = '0;
            col_wt[j]  = '0;
            tap_col    = int'(col) + j - 2;
            for (int i = 0; i < KSIZE; i++) begin
                tap_row = int'(row) + i - 2;
                // taps off the frame carry neither value nor weight
                if (tap_row >= 0 && tap_row < HEIGHT && tap_col >= 0 && tap_col < WIDTH) begin
                    col_sum[j] = col_sum[j]
                               + image_pkg::wsum_t'(line_buf[i * WIDTH + j])
                               * image_pkg::wsum_t'(image_pkg::KERNEL[i][j]);
                    col_wt[j]  = col_wt[j] + image_pkg::wtot_t'(image_pkg::KERNEL[i][j]);
                end
            end
        end
        // fold the five columns
        for (int j = 0; j < KSIZE; j++) begin
            win_sum = win_sum + col_sum[j];
            win_wt  = win_wt + col_wt[j];
        end
    end

    // next state and strobes
    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        shift_en   = 1'b0;
        shift_pix  = in_dout;
        div_start  = 1'b0;
        out_wr_en  = 1'b0;
        frame_end  = 1'b0;
        case (state)
            image_pkg::PROLOGUE: begin
                // one pixel per cycle when the input has one
                if (!in_empty) begin
                    in_rd_en = 1'b1;
                    shift_en = 1'b1;
                    if (prologue_cnt == CNT_W'(PROLOGUE_LEN - 1)) begin
                        next_state = image_pkg::FILTER;
                    end
                end
            end
            image_pkg::FILTER: begin
                // stall only while real pixels are still due
                if (feed_done || !in_empty) begin
                    shift_en   = 1'b1;
                    in_rd_en   = !feed_done;
                    shift_pix  = feed_done ? '0 : in_dout;
                    div_start  = 1'b1;
                    next_state = image_pkg::DIVIDE;
                end
            end
            image_pkg::DIVIDE: begin
                if (div_done) begin
                    next_state = image_pkg::OUTPUT;
                end
            end
            image_pkg::OUTPUT: begin
                // hold the result until the output FIFO has room
                if (!out_full) begin
                    out_wr_en = 1'b1;
                    if (last_pix) begin
                        frame_end  = 1'b1;
                        next_state = image_pkg::PROLOGUE;
                    end else begin
                        next_state = image_pkg::FILTER;
                    end
                end
            end
            default: begin
                next_state = image_pkg::PROLOGUE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= image_pkg::PROLOGUE;
            prologue_cnt <= '0;
            col          <= '0;
            row          <= '0;
        end else begin
            state <= next_state;
            if (frame_end) begin
                prologue_cnt <= '0;
                col          <= '0;
                row          <= '0;
            end else begin
                if (state == image_pkg::PROLOGUE && in_rd_en) begin
                    prologue_cnt <= prologue_cnt + 1'b1;
                end
                // centre moves on once its result is written
                if (out_wr_en) begin
                    if (col == COL_W'(WIDTH - 1)) begin
                        col <= '0;
                        row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
        end
    end

    // line buffer flushed between frames
    always_ff @(posedge clock) begin
        if (frame_end) begin
            line_buf <= '0;
        end else if (shift_en) begin
            line_buf <= {line_buf[1:SHIFT_LEN-1], shift_pix};
        end
    end

    blur_divider u_divider (
        .clock    (clock),
        .reset    (reset),
        .start    (div_start),
        .dividend (win_sum),
        .divisor  (win_wt),
        .done     (div_done),
        .quotient (div_quotient)
    );

    // a full output FIFO holds the engine and its result
    a_hold_when_full: assert property (
        @(posedge clock) disable iff (reset)
        (state == image_pkg::OUTPUT) && out_full
            |=> (state == image_pkg::OUTPUT) && $stable(out_din)
    );

endmodule

`default_nettype wire

/* image_pkg.sv */
`default_nettype none

package image_pkg;

    // one grayscale sample
    typedef logic [7:0] pixel_t;

    // weighted sum of one window
    // worst case 255 * 159 = 40545, fits 16 bits
    typedef logic [15:0] wsum_t;

    // total of the weights that fell inside the frame
    // between 1 and 159, never zero since the centre tap is always in frame
    typedef logic [7:0] wtot_t;

    // one kernel coefficient
    typedef logic [3:0] weight_t;

    // window edge length
    localparam int KSIZE = 5;

    // 5x5 gaussian, rows top to bottom, columns left to right
    localparam weight_t KERNEL [KSIZE][KSIZE] = '{
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd5, 4'd12, 4'd15, 4'd12, 4'd5},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2}
    };

    // blur engine FSM
    typedef enum logic [1:0] {PROLOGUE, FILTER, DIVIDE, OUTPUT} blur_state_t;

endpackage

`default_nettype wire

/* pixel_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              wr_en,
    input  wire image_pkg::pixel_t din,
    output logic                   full,
    input  wire logic              rd_en,
    output image_pkg::pixel_t      dout,
    output logic                   empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // circular storage
    image_pkg::pixel_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // occupancy from 0 to FIFO_DEPTH
    logic [CNT_W-1:0] count;

    logic wr_accept;
    logic rd_accept;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // writes into a full FIFO are dropped
    assign wr_accept = wr_en && !full;
    assign rd_accept = rd_en && !empty;

    // first word fall through shows the head entry
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr_accept) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_accept) begin
                // wrap at depth since depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the level unchanged
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // refused write into a full FIFO keeps level and head
    a_no_write_when_full: assert property (
        @(posedge clock) disable iff (reset)
        full && !rd_en |=> full && $stable(dout)
    );

    // requester reads only while the head is valid
    a_no_read_when_empty: assert property (
        @(posedge clock) disable iff (reset)
        rd_en |-> !empty
    );

endmodule

`default_nettype wire

/* src.f */
image_pkg.sv
pixel_fifo.sv
blur_divider.sv
gaussian_blur.sv
blur_top.sv
blur_checker.sv
blur_tb.sv
